// File: source/chi_link_pkg.sv
// Link layer definitions shared by the state machine and both channels
// Link state encoding and link-credit count types

package chi_link_pkg;

   // Link state, same encoding on the transmit and receive side
   typedef enum logic [1:0] {
      STOP         = 2'b00,
      ACTIVATING   = 2'b01,
      DEACTIVATING = 2'b10,
      RUN          = 2'b11
   } link_state_e;

   // Width of one link-credit count
   localparam int CREDIT_W = 4;

   // Protocol limit on outstanding link credits per channel
   localparam int CREDIT_MAX = 15;

   // One bit per receive buffer in the ownership-release vector
   localparam int RELEASE_W = 15;

   typedef logic [CREDIT_W-1:0] credit_t;

endpackage

// File: source/chi_flit_pkg.sv
// Response channel flit format
// Field layout and opcode list of the response flit

package chi_flit_pkg;

   localparam int NODE_ID_W = 7;
   localparam int TXN_ID_W  = 8;
   localparam int OPCODE_W  = 5;

   // Response opcodes, zero is the link-credit return
   typedef enum logic [OPCODE_W-1:0] {
      LCRD_RETURN = 5'h00,
      COMP        = 5'h01,
      COMP_DBID   = 5'h02,
      DBID_RESP   = 5'h03,
      RETRY_ACK   = 5'h04
   } rsp_opcode_e;

   // 27-bit response flit, target ID in the top bits
   typedef struct packed {
      logic [NODE_ID_W-1:0] tgt_id;
      logic [NODE_ID_W-1:0] src_id;
      logic [TXN_ID_W-1:0]  txn_id;
      rsp_opcode_e          opcode;
   } rsp_flit_t;

   // An all-zero flit carries no content and only returns a credit

endpackage

// File: source/credit_counter.sv
// Link-credit counter
// Counts up and down by one and saturates at zero and MAX_COUNT

module credit_counter #(
   parameter int MAX_COUNT  = 15,
   parameter int INIT_COUNT = 0
) (
   input  logic                  clk,
   input  logic                  resetn,
   input  logic                  incr_i,
   input  logic                  dec_i,
   output chi_link_pkg::credit_t count_o,
   output logic                  nonzero_o,
   output logic                  full_o
);

   localparam chi_link_pkg::credit_t MAX_VAL  = chi_link_pkg::credit_t'(MAX_COUNT);
   localparam chi_link_pkg::credit_t INIT_VAL = chi_link_pkg::credit_t'(INIT_COUNT);

   chi_link_pkg::credit_t count_q;
   logic                  at_zero;
   logic                  at_max;

   assign at_zero = (count_q == '0);
   assign at_max  = (count_q == MAX_VAL);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         count_q <= INIT_VAL;
      end else if (incr_i && !dec_i && !at_max) begin
         count_q <= count_q + 1'b1;
      end else if (dec_i && !incr_i && !at_zero) begin
         count_q <= count_q - 1'b1;
      end
   end

   assign count_o   = count_q;
   assign nonzero_o = !at_zero;
   assign full_o    = at_max;

endmodule

// File: source/link_fsm.sv
// Link activation state machine
// Separate transmit and receive link states driven by the local
// configuration inputs and the remote activation handshake

module link_fsm (
   input  logic                      clk,
   input  logic                      resetn,
   input  logic                      configure_i,
   input  logic                      go_to_lp_i,
   input  logic                      txlinkactiveack_i,
   input  logic                      rxlinkactivereq_i,
   input  logic                      tx_empty_i,
   input  logic                      rx_all_back_i,
   output chi_link_pkg::link_state_e tx_state_o,
   output chi_link_pkg::link_state_e rx_state_o,
   output logic                      txlinkactivereq_o,
   output logic                      rxlinkactiveack_o
);

   // Remote handshake inputs after one register stage
   logic ack_q;
   logic req_q;

   chi_link_pkg::link_state_e tx_state_q;
   chi_link_pkg::link_state_e tx_state_d;
   chi_link_pkg::link_state_e rx_state_q;
   chi_link_pkg::link_state_e rx_state_d;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ack_q <= 1'b0;
         req_q <= 1'b0;
      end else begin
         ack_q <= txlinkactiveack_i;
         req_q <= rxlinkactivereq_i;
      end
   end

   // Transmit side, started and stopped locally
   always_comb begin
      tx_state_d = tx_state_q;
      case (tx_state_q)
         chi_link_pkg::STOP: begin
            if (configure_i && !go_to_lp_i) begin
               tx_state_d = chi_link_pkg::ACTIVATING;
            end
         end
         chi_link_pkg::ACTIVATING: begin
            if (ack_q) begin
               tx_state_d = chi_link_pkg::RUN;
            end
         end
         chi_link_pkg::RUN: begin
            if (configure_i && go_to_lp_i) begin
               tx_state_d = chi_link_pkg::DEACTIVATING;
            end
         end
         chi_link_pkg::DEACTIVATING: begin
            // Stay until the remote drops its ack and all credits went back
            if (!ack_q && tx_empty_i) begin
               tx_state_d = chi_link_pkg::STOP;
            end
         end
         default: tx_state_d = chi_link_pkg::STOP;
      endcase
   end

   // Receive side, follows the remote request
   always_comb begin
      rx_state_d = rx_state_q;
      case (rx_state_q)
         chi_link_pkg::STOP: begin
            if (req_q && configure_i) begin
               rx_state_d = chi_link_pkg::ACTIVATING;
            end
         end
         chi_link_pkg::ACTIVATING: begin
            rx_state_d = chi_link_pkg::RUN;
         end
         chi_link_pkg::RUN: begin
            if (!req_q) begin
               rx_state_d = chi_link_pkg::DEACTIVATING;
            end
         end
         chi_link_pkg::DEACTIVATING: begin
            // Remote hands back every granted credit before we stop
            if (rx_all_back_i) begin
               rx_state_d = chi_link_pkg::STOP;
            end
         end
         default: rx_state_d = chi_link_pkg::STOP;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         tx_state_q <= chi_link_pkg::STOP;
         rx_state_q <= chi_link_pkg::STOP;
      end else begin
         tx_state_q <= tx_state_d;
         rx_state_q <= rx_state_d;
      end
   end

   assign tx_state_o = tx_state_q;
   assign rx_state_o = rx_state_q;

   assign txlinkactivereq_o = (tx_state_q == chi_link_pkg::ACTIVATING) ||
                              (tx_state_q == chi_link_pkg::RUN);
   assign rxlinkactiveack_o = (rx_state_q == chi_link_pkg::ACTIVATING) ||
                              (rx_state_q == chi_link_pkg::RUN);

endmodule

// File: source/tx_flit_channel.sv
// Transmit response channel
// Registers user flits onto the link, spends one credit per flit and
// returns leftover credits as zero flits while the link deactivates

module tx_flit_channel (
   input  logic                      clk,
   input  logic                      resetn,
   input  chi_link_pkg::link_state_e tx_state_i,
   input  chi_flit_pkg::rsp_flit_t   tx_flit_i,
   input  logic                      tx_valid_i,
   input  logic                      txlcrdv_i,
   output chi_flit_pkg::rsp_flit_t   txflit_o,
   output logic                      txflitv_o,
   output logic                      tx_credit_ok_o,
   output logic                      tx_empty_o
);

   logic credit_avail;
   logic lcrd_return;
   logic credit_use;

   // One held credit goes back per cycle in DEACTIVATING
   assign lcrd_return = (tx_state_i == chi_link_pkg::DEACTIVATING) && credit_avail;
   assign credit_use  = tx_valid_i || lcrd_return;

   credit_counter #(
      .MAX_COUNT  (chi_link_pkg::CREDIT_MAX),
      .INIT_COUNT (0)
   ) i_tx_credits (
      .clk       (clk),
      .resetn    (resetn),
      .incr_i    (txlcrdv_i),
      .dec_i     (credit_use),
      .count_o   (),
      .nonzero_o (credit_avail),
      .full_o    ()
   );

   always_ff @(posedge clk) begin
      if (!resetn) begin
         txflitv_o <= 1'b0;
      end else begin
         txflitv_o <= credit_use;
      end
   end

   // Credit return flit is all zero, opcode LCRD_RETURN
   always_ff @(posedge clk) begin
      if (lcrd_return) begin
         txflit_o <= chi_flit_pkg::rsp_flit_t'('0);
      end else begin
         txflit_o <= tx_flit_i;
      end
   end

   assign tx_credit_ok_o = credit_avail && (tx_state_i == chi_link_pkg::RUN);
   assign tx_empty_o     = !credit_avail;

endmodule

// File: source/rx_flit_channel.sv
// Receive response channel
// Registers incoming flits and hands link credits to the remote side
// as buffers are refilled or released by software

module rx_flit_channel #(
   parameter int RX_BUFFERS = 8
) (
   input  logic                                 clk,
   input  logic                                 resetn,
   input  chi_link_pkg::link_state_e            rx_state_i,
   input  chi_flit_pkg::rsp_flit_t              rxflit_i,
   input  logic                                 rxflitv_i,
   input  logic                                 refill_i,
   input  chi_link_pkg::credit_t                refill_count_i,
   input  logic [chi_link_pkg::RELEASE_W-1:0]   release_i,
   output chi_flit_pkg::rsp_flit_t              rx_flit_o,
   output logic                                 rx_valid_o,
   output logic                                 rxlcrdv_o,
   output logic                                 rx_all_back_o
);

   chi_link_pkg::credit_t               pending_q;
   chi_link_pkg::credit_t               release_cnt;
   logic [chi_link_pkg::CREDIT_W:0]     pending_sum;
   logic                                credit_avail;
   logic                                grant;

   // Number of buffers freed by one release vector
   function automatic chi_link_pkg::credit_t count_ones(
      input logic [chi_link_pkg::RELEASE_W-1:0] v
   );
      chi_link_pkg::credit_t n;
      n = '0;
      for (int i = 0; i < chi_link_pkg::RELEASE_W; i++) begin
         n = n + chi_link_pkg::credit_t'(v[i]);
      end
      return n;
   endfunction

   assign release_cnt = count_ones(release_i);
   assign pending_sum = {1'b0, pending_q} + {1'b0, release_cnt};

   // Grants wait while software updates the pending count
   assign grant = !refill_i && !(|release_i) &&
                  (rx_state_i == chi_link_pkg::RUN) &&
                  (pending_q != '0) && credit_avail;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         pending_q <= '0;
      end else if (refill_i) begin
         pending_q <= refill_count_i;
      end else if (|release_i) begin
         // Clip at the protocol limit
         if (pending_sum > chi_link_pkg::CREDIT_MAX) begin
            pending_q <= chi_link_pkg::credit_t'(chi_link_pkg::CREDIT_MAX);
         end else begin
            pending_q <= pending_sum[chi_link_pkg::CREDIT_W-1:0];
         end
      end else if (grant) begin
         pending_q <= pending_q - 1'b1;
      end
   end

   // Credits held locally, a flit brings one back and a grant gives one away
   credit_counter #(
      .MAX_COUNT  (RX_BUFFERS),
      .INIT_COUNT (RX_BUFFERS)
   ) i_rx_credits (
      .clk       (clk),
      .resetn    (resetn),
      .incr_i    (rxflitv_i),
      .dec_i     (grant),
      .count_o   (),
      .nonzero_o (credit_avail),
      .full_o    (rx_all_back_o)
   );

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rx_valid_o <= 1'b0;
         rxlcrdv_o  <= 1'b0;
      end else begin
         rx_valid_o <= rxflitv_i;
         rxlcrdv_o  <= grant;
      end
   end

   always_ff @(posedge clk) begin
      rx_flit_o <= rxflit_i;
   end

endmodule

// File: source/chi_link_top.sv
// Link layer of one coherent interconnect port
// Link state machine plus one transmit and one receive response channel

module chi_link_top #(
   parameter int RX_BUFFERS = 8
) (
   input  logic                                 clk,
   input  logic                                 resetn,
   input  logic                                 configure_i,
   input  logic                                 go_to_lp_i,
   input  logic                                 txlinkactiveack_i,
   input  logic                                 rxlinkactivereq_i,
   output logic                                 txlinkactivereq_o,
   output logic                                 rxlinkactiveack_o,
   output chi_link_pkg::link_state_e            tx_state_o,
   output chi_link_pkg::link_state_e            rx_state_o,
   input  chi_flit_pkg::rsp_flit_t              tx_flit_i,
   input  logic                                 tx_valid_i,
   input  logic                                 txlcrdv_i,
   output chi_flit_pkg::rsp_flit_t              txflit_o,
   output logic                                 txflitv_o,
   output logic                                 tx_credit_ok_o,
   input  chi_flit_pkg::rsp_flit_t              rxflit_i,
   input  logic                                 rxflitv_i,
   input  logic                                 refill_i,
   input  chi_link_pkg::credit_t                refill_count_i,
   input  logic [chi_link_pkg::RELEASE_W-1:0]   release_i,
   output chi_flit_pkg::rsp_flit_t              rx_flit_o,
   output logic                                 rx_valid_o,
   output logic                                 rxlcrdv_o
);

   logic tx_empty;
   logic rx_all_back;

   link_fsm i_link_fsm (
      .clk               (clk),
      .resetn            (resetn),
      .configure_i       (configure_i),
      .go_to_lp_i        (go_to_lp_i),
      .txlinkactiveack_i (txlinkactiveack_i),
      .rxlinkactivereq_i (rxlinkactivereq_i),
      .tx_empty_i        (tx_empty),
      .rx_all_back_i     (rx_all_back),
      .tx_state_o        (tx_state_o),
      .rx_state_o        (rx_state_o),
      .txlinkactivereq_o (txlinkactivereq_o),
      .rxlinkactiveack_o (rxlinkactiveack_o)
   );

   tx_flit_channel i_tx_channel (
      .clk            (clk),
      .resetn         (resetn),
      .tx_state_i     (tx_state_o),
      .tx_flit_i      (tx_flit_i),
      .tx_valid_i     (tx_valid_i),
      .txlcrdv_i      (txlcrdv_i),
      .txflit_o       (txflit_o),
      .txflitv_o      (txflitv_o),
      .tx_credit_ok_o (tx_credit_ok_o),
      .tx_empty_o     (tx_empty)
   );

   rx_flit_channel #(
      .RX_BUFFERS (RX_BUFFERS)
   ) i_rx_channel (
      .clk            (clk),
      .resetn         (resetn),
      .rx_state_i     (rx_state_o),
      .rxflit_i       (rxflit_i),
      .rxflitv_i      (rxflitv_i),
      .refill_i       (refill_i),
      .refill_count_i (refill_count_i),
      .release_i      (release_i),
      .rx_flit_o      (rx_flit_o),
      .rx_valid_o     (rx_valid_o),
      .rxlcrdv_o      (rxlcrdv_o),
      .rx_all_back_o  (rx_all_back)
   );

endmodule

// File: sim/tb_chi_link.sv
// Testbench for the link layer top level
// Walks through activation, transmit credits, refill and release grants,
// the receive path and deactivation with credit return

module tb_chi_link;

   localparam int RX_BUFFERS   = 8;
   localparam int MAX_CYCLES   = 1200;
   localparam int TX_CREDITS   = 5;
   localparam int REFILL_N     = 5;
   localparam int RX_FLITS     = 2;
   localparam int HELD_CREDITS = 3;
   // Buffers 0, 5 and 9 released
   localparam logic [chi_link_pkg::RELEASE_W-1:0] RELEASE_VEC = 15'h0221;
   localparam int RELEASE_M    = 3;

   logic                                 clk;
   logic                                 resetn;
   logic                                 configure_i;
   logic                                 go_to_lp_i;
   logic                                 txlinkactiveack_i;
   logic                                 rxlinkactivereq_i;
   logic                                 txlinkactivereq_o;
   logic                                 rxlinkactiveack_o;
   chi_link_pkg::link_state_e            tx_state_o;
   chi_link_pkg::link_state_e            rx_state_o;
   chi_flit_pkg::rsp_flit_t              tx_flit_i;
   logic                                 tx_valid_i;
   logic                                 txlcrdv_i;
   chi_flit_pkg::rsp_flit_t              txflit_o;
   logic                                 txflitv_o;
   logic                                 tx_credit_ok_o;
   chi_flit_pkg::rsp_flit_t              rxflit_i;
   logic                                 rxflitv_i;
   logic                                 refill_i;
   chi_link_pkg::credit_t                refill_count_i;
   logic [chi_link_pkg::RELEASE_W-1:0]   release_i;
   chi_flit_pkg::rsp_flit_t              rx_flit_o;
   logic                                 rx_valid_o;
   logic                                 rxlcrdv_o;

   logic [15:0]             lfsr;
   string                   cur_test;
   int                      err_cnt;
   int                      test_err_start;
   int                      tests_run;
   int                      tests_failed;
   int                      cycle_cnt;
   int                      grant_cnt;
   int                      txv_cnt;
   int                      tx_zero_cnt;
   int                      guard;
   int                      rx_out;
   chi_flit_pkg::rsp_flit_t f;

   chi_link_top #(
      .RX_BUFFERS (RX_BUFFERS)
   ) i_dut (
      .clk               (clk),
      .resetn            (resetn),
      .configure_i       (configure_i),
      .go_to_lp_i        (go_to_lp_i),
      .txlinkactiveack_i (txlinkactiveack_i),
      .rxlinkactivereq_i (rxlinkactivereq_i),
      .txlinkactivereq_o (txlinkactivereq_o),
      .rxlinkactiveack_o (rxlinkactiveack_o),
      .tx_state_o        (tx_state_o),
      .rx_state_o        (rx_state_o),
      .tx_flit_i         (tx_flit_i),
      .tx_valid_i        (tx_valid_i),
      .txlcrdv_i         (txlcrdv_i),
      .txflit_o          (txflit_o),
      .txflitv_o         (txflitv_o),
      .tx_credit_ok_o    (tx_credit_ok_o),
      .rxflit_i          (rxflit_i),
      .rxflitv_i         (rxflitv_i),
      .refill_i          (refill_i),
      .refill_count_i    (refill_count_i),
      .release_i         (release_i),
      .rx_flit_o         (rx_flit_o),
      .rx_valid_o        (rx_valid_o),
      .rxlcrdv_o         (rxlcrdv_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // Opcode kept nonzero so that a user flit never looks like a credit return
   task automatic random_flit(output chi_flit_pkg::rsp_flit_t r);
      logic [31:0] v;
      take_bits(7, v);
      r.tgt_id = v[6:0];
      take_bits(7, v);
      r.src_id = v[6:0];
      take_bits(8, v);
      r.txn_id = v[7:0];
      take_bits(2, v);
      r.opcode = chi_flit_pkg::rsp_opcode_e'({3'b000, v[1:0]} + 5'd1);
   endtask

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (act == exp) else begin
         $display("ERR %s %s expected %0h actual %0h", cur_test, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_err_start = err_cnt;
   endtask

   task automatic end_test();
      tests_run++;
      if (err_cnt == test_err_start) begin
         $display("test %s passed", cur_test);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", cur_test, err_cnt - test_err_start);
      end
   endtask

   task automatic give_tx_credits(input int n);
      repeat (n) begin
         @(posedge clk);
         txlcrdv_i <= 1'b1;
      end
      @(posedge clk);
      txlcrdv_i <= 1'b0;
   endtask

   // Received flit strobe comes out one cycle later
   assert property (@(posedge clk) disable iff (!resetn) rxflitv_i |=> rx_valid_o)
      else begin
         $display("ERR %s rx_valid_o expected 1 actual 0", cur_test);
         err_cnt++;
      end

   // Pulse counters for grants and transmitted flits
   always @(negedge clk) begin
      if (resetn) begin
         if (rxlcrdv_o) begin
            grant_cnt++;
         end
         if (txflitv_o) begin
            txv_cnt++;
            if (txflit_o == chi_flit_pkg::rsp_flit_t'('0)) begin
               tx_zero_cnt++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Run stopped at the cycle limit before the tests finished");
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      resetn            = 1'b0;
      configure_i       = 1'b0;
      go_to_lp_i        = 1'b0;
      txlinkactiveack_i = 1'b0;
      rxlinkactivereq_i = 1'b0;
      tx_flit_i         = '0;
      tx_valid_i        = 1'b0;
      txlcrdv_i         = 1'b0;
      rxflit_i          = '0;
      rxflitv_i         = 1'b0;
      refill_i          = 1'b0;
      refill_count_i    = '0;
      release_i         = '0;
      lfsr              = 16'd18;
      err_cnt           = 0;
      tests_run         = 0;
      tests_failed      = 0;
      cycle_cnt         = 0;
      grant_cnt         = 0;
      txv_cnt           = 0;
      tx_zero_cnt       = 0;
      cur_test          = "reset";
      repeat (4) @(posedge clk);
      resetn <= 1'b1;

      start_test("activation");
      @(negedge clk);
      check_val("tx_state_o", chi_link_pkg::STOP, tx_state_o);
      check_val("rx_state_o", chi_link_pkg::STOP, rx_state_o);
      check_val("txlinkactivereq_o", 1'b0, txlinkactivereq_o);
      check_val("rxlinkactiveack_o", 1'b0, rxlinkactiveack_o);
      @(posedge clk);
      configure_i <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_val("tx_state_o", chi_link_pkg::ACTIVATING, tx_state_o);
      check_val("txlinkactivereq_o", 1'b1, txlinkactivereq_o);
      @(posedge clk);
      txlinkactiveack_i <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_val("tx_state_o", chi_link_pkg::ACTIVATING, tx_state_o);
      @(posedge clk);
      @(negedge clk);
      check_val("tx_state_o", chi_link_pkg::RUN, tx_state_o);
      check_val("txlinkactivereq_o", 1'b1, txlinkactivereq_o);
      @(posedge clk);
      rxlinkactivereq_i <= 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_val("rx_state_o", chi_link_pkg::ACTIVATING, rx_state_o);
      check_val("rxlinkactiveack_o", 1'b1, rxlinkactiveack_o);
      @(posedge clk);
      @(negedge clk);
      check_val("rx_state_o", chi_link_pkg::RUN, rx_state_o);
      check_val("rxlinkactiveack_o", 1'b1, rxlinkactiveack_o);
      end_test();

      start_test("tx_credits");
      check_val("tx_credit_ok_o", 1'b0, tx_credit_ok_o);
      give_tx_credits(TX_CREDITS);
      @(negedge clk);
      check_val("tx_credit_ok_o", 1'b1, tx_credit_ok_o);
      for (int i = 0; i < TX_CREDITS; i++) begin
         random_flit(f);
         @(posedge clk);
         tx_flit_i  <= f;
         tx_valid_i <= 1'b1;
         @(posedge clk);
         tx_valid_i <= 1'b0;
         @(negedge clk);
         check_val("txflitv_o", 1'b1, txflitv_o);
         check_val("txflit_o", f, txflit_o);
         check_val("tx_credit_ok_o", i < TX_CREDITS - 1, tx_credit_ok_o);
      end
      end_test();

      start_test("refill");
      @(posedge clk);
      grant_cnt = 0;
      refill_i       <= 1'b1;
      refill_count_i <= chi_link_pkg::credit_t'(REFILL_N);
      @(posedge clk);
      refill_i <= 1'b0;
      guard = 0;
      while (grant_cnt < REFILL_N && guard < 50) begin
         @(negedge clk);
         guard++;
      end
      if (grant_cnt < REFILL_N) begin
         $display("refill: the credit grants did not all arrive in time");
         err_cnt++;
      end
      repeat (6) @(negedge clk);
      check_val("grant count", REFILL_N, grant_cnt);
      end_test();

      start_test("release_rx");
      for (int i = 0; i < RX_FLITS; i++) begin
         random_flit(f);
         @(posedge clk);
         rxflit_i  <= f;
         rxflitv_i <= 1'b1;
         @(posedge clk);
         rxflitv_i <= 1'b0;
         @(negedge clk);
         check_val("rx_valid_o", 1'b1, rx_valid_o);
         check_val("rx_flit_o", f, rx_flit_o);
      end
      @(posedge clk);
      grant_cnt = 0;
      release_i <= RELEASE_VEC;
      @(posedge clk);
      release_i <= '0;
      guard = 0;
      while (grant_cnt < RELEASE_M && guard < 50) begin
         @(negedge clk);
         guard++;
      end
      if (grant_cnt < RELEASE_M) begin
         $display("release_rx: the credit grants did not all arrive in time");
         err_cnt++;
      end
      repeat (6) @(negedge clk);
      check_val("grant count", RELEASE_M, grant_cnt);
      end_test();

      start_test("deactivation");
      give_tx_credits(HELD_CREDITS);
      @(posedge clk);
      txv_cnt     = 0;
      tx_zero_cnt = 0;
      go_to_lp_i <= 1'b1;
      guard = 0;
      while (txv_cnt < HELD_CREDITS && guard < 50) begin
         @(negedge clk);
         guard++;
      end
      if (txv_cnt < HELD_CREDITS) begin
         $display("deactivation: the credit return flits did not all arrive in time");
         err_cnt++;
      end
      repeat (4) @(negedge clk);
      check_val("return flits", HELD_CREDITS, txv_cnt);
      check_val("zero return flits", HELD_CREDITS, tx_zero_cnt);
      // Acknowledge still high, so the transmit side must wait
      check_val("tx_state_o", chi_link_pkg::DEACTIVATING, tx_state_o);
      check_val("txlinkactivereq_o", 1'b0, txlinkactivereq_o);
      @(posedge clk);
      txlinkactiveack_i <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      check_val("tx_state_o", chi_link_pkg::DEACTIVATING, tx_state_o);
      @(posedge clk);
      @(negedge clk);
      check_val("tx_state_o", chi_link_pkg::STOP, tx_state_o);
      check_val("txlinkactivereq_o", 1'b0, txlinkactivereq_o);
      @(posedge clk);
      rxlinkactivereq_i <= 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_val("rx_state_o", chi_link_pkg::DEACTIVATING, rx_state_o);
      check_val("rxlinkactiveack_o", 1'b0, rxlinkactiveack_o);
      // Credits still out with the remote side
      rx_out = REFILL_N + RELEASE_M - RX_FLITS;
      for (int i = 0; i < rx_out; i++) begin
         @(posedge clk);
         rxflit_i  <= '0;
         rxflitv_i <= 1'b1;
         @(posedge clk);
         rxflitv_i <= 1'b0;
         @(negedge clk);
         check_val("rx_state_o", chi_link_pkg::DEACTIVATING, rx_state_o);
      end
      @(posedge clk);
      @(negedge clk);
      check_val("rx_state_o", chi_link_pkg::STOP, rx_state_o);
      check_val("rxlinkactiveack_o", 1'b0, rxlinkactiveack_o);
      end_test();

      $display("tests run: %0d, tests failed: %0d, errors: %0d",
               tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: files.f
source/chi_link_pkg.sv
source/chi_flit_pkg.sv
source/credit_counter.sv
source/link_fsm.sv
source/tx_flit_channel.sv
source/rx_flit_channel.sv
source/chi_link_top.sv
sim/tb_chi_link.sv
